// File: lockstep_bus_mux.sv
// ************************************************************
// Request, response and fetch enable routing per mode
// ************************************************************
`timescale 1ns/1ps

module lockstep_bus_mux (
  input  lockstep_pkg::red_mode_e                            red_mode_i,
  input  lockstep_pkg::core_req_t [lockstep_pkg::NCores-1:0] core_req_i,
  input  lockstep_pkg::core_req_t                            voted_i,
  output lockstep_pkg::core_req_t [lockstep_pkg::NCores-1:0] intc_req_o,
  input  lockstep_pkg::bus_rsp_t  [lockstep_pkg::NCores-1:0] intc_rsp_i,
  output lockstep_pkg::bus_rsp_t  [lockstep_pkg::NCores-1:0] core_rsp_o,
  input  lockstep_pkg::core_vec_t                            intc_fetch_en_i,
  output lockstep_pkg::core_vec_t                            core_fetch_en_o
);
  import lockstep_pkg::*;

  logic split;

  assign split = (red_mode_i == NON_TMR);

  // Requests towards the interconnect
  always_comb begin
    for (int i = 0; i < NCores; i++) begin
      intc_req_o[i] = core_req_i[i];
    end
    if (!split) begin
      // Only the voted request reaches the bus
      intc_req_o[0] = voted_i;
      for (int i = 1; i < NCores; i++) begin
        // Address and data stay visible, but nothing is requested
        intc_req_o[i].busy      = 1'b0;
        intc_req_o[i].instr_req = 1'b0;
        intc_req_o[i].data_req  = 1'b0;
      end
    end
  end

  // Responses back to the cores
  always_comb begin
    for (int i = 0; i < NCores; i++) begin
      if (split) begin
        core_rsp_o[i] = intc_rsp_i[i];
      end else begin
        core_rsp_o[i] = intc_rsp_i[0];
      end
    end
  end

  // Fetch enable follows channel 0 in lockstep
  always_comb begin
    for (int i = 0; i < NCores; i++) begin
      if (split) begin
        core_fetch_en_o[i] = intc_fetch_en_i[i];
      end else begin
        core_fetch_en_o[i] = intc_fetch_en_i[0];
      end
    end
  end

endmodule

// File: lockstep_mode_fsm.sv
// ************************************************************
// Redundancy mode FSM with setback and counter increment
// ************************************************************
`timescale 1ns/1ps

module lockstep_mode_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_vec_t single_err_i,
  input  lockstep_pkg::mode_cfg_t mode_cfg_i,
  input  logic                    sp_store_nz_i,
  input  logic                    fetch_en0_i,
  input  logic                    busy0_i,
  input  logic                    cores_synch_i,
  output lockstep_pkg::red_mode_e red_mode_o,
  output lockstep_pkg::core_vec_t mis_inc_o,
  output logic                    force_clr_o,
  output logic                    setback_o,
  output logic                    resynch_req_o
);
  import lockstep_pkg::*;

  red_mode_e red_mode_d, red_mode_q;
  logic      setback_d, setback_q;
  logic      mismatch;

  assign mismatch = (single_err_i != '0);

  // Later conditions override earlier ones
  always_comb begin
    red_mode_d  = red_mode_q;
    setback_d   = 1'b0;
    mis_inc_o   = '0;
    force_clr_o = 1'b0;

    // Mismatch or forced resynch while running
    if (red_mode_q == TMR_RUN) begin
      force_clr_o = mode_cfg_i.force_resynch;
      if (mismatch || mode_cfg_i.force_resynch) begin
        if (!mode_cfg_i.delay_resynch) begin
          red_mode_d = TMR_UNLOAD;
        end
      end
      // Only a lone faulty core is counted
      if ($onehot(single_err_i)) begin
        mis_inc_o = single_err_i;
      end
    end

    // Reload the cores once software has saved the state
    if (red_mode_q == TMR_UNLOAD && sp_store_nz_i) begin
      red_mode_d = TMR_RELOAD;
      setback_d  = mode_cfg_i.setback;
    end

    if (red_mode_q == TMR_RELOAD) begin
      if (!sp_store_nz_i) begin
        red_mode_d = TMR_RUN;
      end else if (mismatch && mode_cfg_i.setback && mode_cfg_i.reload_setback) begin
        // Retry the reload from scratch
        setback_d = 1'b1;
      end
    end

    // Idle cores before startup take the mode from the split bit
    if (!fetch_en0_i && !busy0_i) begin
      red_mode_d = mode_cfg_i.split ? NON_TMR : TMR_RUN;
    end

    if (red_mode_q == TMR_RUN && mode_cfg_i.split) begin
      red_mode_d = NON_TMR;
    end

    // Back to lockstep once the cores report they are aligned
    if (red_mode_q == NON_TMR && cores_synch_i && !mode_cfg_i.split) begin
      red_mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      red_mode_q <= TMR_RUN;
      setback_q  <= 1'b0;
    end else begin
      red_mode_q <= red_mode_d;
      setback_q  <= setback_d;
    end
  end

  assign red_mode_o    = red_mode_q;
  assign setback_o     = setback_q;
  assign resynch_req_o = mismatch && (red_mode_q == TMR_RUN || red_mode_q == TMR_RELOAD);

endmodule

// File: lockstep_pkg.sv
// ************************************************************
// Shared widths, bus request and response structs, mode enum
// and register map of the triple-core lockstep unit
// ************************************************************
package lockstep_pkg;

  // Number of redundant cores
  localparam int unsigned NCores = 3;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = 4;
  localparam int unsigned RegAddrWidth = 3;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;
  typedef logic [NCores-1:0]       core_vec_t;
  typedef logic [31:0]             counter_t;

  // Everything one core drives towards the interconnect
  typedef struct packed {
    logic  busy;
    logic  instr_req;
    addr_t instr_addr;
    logic  data_req;
    addr_t data_add;
    logic  data_wen;
    data_t data_wdata;
    be_t   data_be;
  } core_req_t;

  // Responses of one interconnect channel
  typedef struct packed {
    logic  instr_gnt;
    data_t instr_rdata;
    logic  instr_rvalid;
    logic  instr_err;
    logic  data_gnt;
    data_t data_rdata;
    logic  data_rvalid;
    logic  data_err;
  } bus_rsp_t;

  // Mode register with split in bit 0 and force_resynch in bit 4
  typedef struct packed {
    logic force_resynch;
    logic reload_setback;
    logic setback;
    logic delay_resynch;
    logic split;
  } mode_cfg_t;

  typedef enum logic [1:0] {NON_TMR, TMR_RUN, TMR_UNLOAD, TMR_RELOAD} red_mode_e;

  // busy + instr_req + data_req + instr_addr
  localparam int unsigned MainVoteWidth = 3 + AddrWidth;
  // data_add + data_wen + data_wdata + data_be
  localparam int unsigned DataVoteWidth = AddrWidth + 1 + DataWidth + BeWidth;

  localparam reg_addr_t RegMode    = 3'd0;
  localparam reg_addr_t RegSpStore = 3'd1;
  localparam reg_addr_t RegMis0    = 3'd2;
  localparam reg_addr_t RegMis1    = 3'd3;
  localparam reg_addr_t RegMis2    = 3'd4;
  localparam reg_addr_t RegStatus  = 3'd5;

endpackage

// File: lockstep_regs.sv
// ************************************************************
// Mode bits, stack-pointer store, mismatch counters, status
// ************************************************************
`timescale 1ns/1ps

module lockstep_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reg_we_i,
  input  lockstep_pkg::reg_addr_t reg_addr_i,
  input  lockstep_pkg::data_t     reg_wdata_i,
  output lockstep_pkg::data_t     reg_rdata_o,
  input  lockstep_pkg::core_vec_t mis_inc_i,
  input  logic                    force_clr_i,
  input  lockstep_pkg::red_mode_e red_mode_i,
  output lockstep_pkg::mode_cfg_t mode_cfg_o,
  output logic                    sp_store_nz_o
);
  import lockstep_pkg::*;

  localparam int unsigned CfgWidth = $bits(mode_cfg_t);

  mode_cfg_t                mode_cfg_q;
  data_t                    sp_store_q;
  counter_t [NCores-1:0]    mis_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_cfg_q <= '0;
      sp_store_q <= '0;
      mis_cnt_q  <= '0;
    end else begin
      // A software write overrides a hardware update in the same cycle
      if (force_clr_i) begin
        mode_cfg_q.force_resynch <= 1'b0;
      end
      for (int i = 0; i < NCores; i++) begin
        if (mis_inc_i[i]) begin
          mis_cnt_q[i] <= mis_cnt_q[i] + counter_t'(1);
        end
      end
      if (reg_we_i) begin
        case (reg_addr_i)
          RegMode:    mode_cfg_q   <= mode_cfg_t'(reg_wdata_i[CfgWidth-1:0]);
          RegSpStore: sp_store_q   <= reg_wdata_i;
          RegMis0:    mis_cnt_q[0] <= reg_wdata_i;
          RegMis1:    mis_cnt_q[1] <= reg_wdata_i;
          RegMis2:    mis_cnt_q[2] <= reg_wdata_i;
          default:    ;
        endcase
      end
    end
  end

  // Combinational readback
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      RegMode:    reg_rdata_o[CfgWidth-1:0] = mode_cfg_q;
      RegSpStore: reg_rdata_o = sp_store_q;
      RegMis0:    reg_rdata_o = mis_cnt_q[0];
      RegMis1:    reg_rdata_o = mis_cnt_q[1];
      RegMis2:    reg_rdata_o = mis_cnt_q[2];
      RegStatus:  reg_rdata_o[$bits(red_mode_e)-1:0] = red_mode_i;
      default:    reg_rdata_o = '0;
    endcase
  end

  assign mode_cfg_o    = mode_cfg_q;
  assign sp_store_nz_o = (sp_store_q != '0);

endmodule

// File: lockstep_top.sv
// ************************************************************
// Triple-core lockstep unit top level
// ************************************************************
`timescale 1ns/1ps

module lockstep_top (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               reg_we_i,
  input  lockstep_pkg::reg_addr_t                            reg_addr_i,
  input  lockstep_pkg::data_t                                reg_wdata_i,
  output lockstep_pkg::data_t                                reg_rdata_o,
  input  logic                                               cores_synch_i,
  input  lockstep_pkg::core_req_t [lockstep_pkg::NCores-1:0] core_req_i,
  output lockstep_pkg::core_req_t [lockstep_pkg::NCores-1:0] intc_req_o,
  input  lockstep_pkg::bus_rsp_t  [lockstep_pkg::NCores-1:0] intc_rsp_i,
  output lockstep_pkg::bus_rsp_t  [lockstep_pkg::NCores-1:0] core_rsp_o,
  input  lockstep_pkg::core_vec_t                            intc_fetch_en_i,
  output lockstep_pkg::core_vec_t                            core_fetch_en_o,
  output lockstep_pkg::core_vec_t                            core_setback_o,
  output logic                                               single_mismatch_o,
  output logic                                               triple_mismatch_o,
  output logic                                               resynch_req_o
);
  import lockstep_pkg::*;

  core_req_t voted;
  core_vec_t single_err;
  logic      triple_err;
  red_mode_e red_mode;
  core_vec_t mis_inc;
  logic      force_clr;
  logic      setback;
  mode_cfg_t mode_cfg;
  logic      sp_store_nz;

  assign core_setback_o    = {NCores{setback}};
  assign single_mismatch_o = (single_err != '0);
  assign triple_mismatch_o = triple_err;

  lockstep_vote_stage u_vote_stage (
    .core_req_i   ( core_req_i ),
    .voted_o      ( voted      ),
    .single_err_o ( single_err ),
    .triple_err_o ( triple_err )
  );

  lockstep_regs u_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .reg_we_i      ( reg_we_i    ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .mis_inc_i     ( mis_inc     ),
    .force_clr_i   ( force_clr   ),
    .red_mode_i    ( red_mode    ),
    .mode_cfg_o    ( mode_cfg    ),
    .sp_store_nz_o ( sp_store_nz )
  );

  lockstep_mode_fsm u_mode_fsm (
    .clk_i         ( clk_i              ),
    .rst_ni        ( rst_ni             ),
    .single_err_i  ( single_err         ),
    .mode_cfg_i    ( mode_cfg           ),
    .sp_store_nz_i ( sp_store_nz        ),
    .fetch_en0_i   ( intc_fetch_en_i[0] ),
    .busy0_i       ( core_req_i[0].busy ),
    .cores_synch_i ( cores_synch_i      ),
    .red_mode_o    ( red_mode           ),
    .mis_inc_o     ( mis_inc            ),
    .force_clr_o   ( force_clr          ),
    .setback_o     ( setback            ),
    .resynch_req_o ( resynch_req_o      )
  );

  lockstep_bus_mux u_bus_mux (
    .red_mode_i      ( red_mode        ),
    .core_req_i      ( core_req_i      ),
    .voted_i         ( voted           ),
    .intc_req_o      ( intc_req_o      ),
    .intc_rsp_i      ( intc_rsp_i      ),
    .core_rsp_o      ( core_rsp_o      ),
    .intc_fetch_en_i ( intc_fetch_en_i ),
    .core_fetch_en_o ( core_fetch_en_o )
  );

endmodule

// File: lockstep_vote_stage.sv
// ************************************************************
// Main and data vote of the core requests, merged error flags
// ************************************************************
`timescale 1ns/1ps

module lockstep_vote_stage (
  input  lockstep_pkg::core_req_t [lockstep_pkg::NCores-1:0] core_req_i,
  output lockstep_pkg::core_req_t                            voted_o,
  output lockstep_pkg::core_vec_t                            single_err_o,
  output logic                                               triple_err_o
);
  import lockstep_pkg::*;

  logic [NCores-1:0][MainVoteWidth-1:0] main_in;
  logic [NCores-1:0][DataVoteWidth-1:0] data_in;
  logic [MainVoteWidth-1:0]             main_out;
  logic [DataVoteWidth-1:0]             data_out;
  logic                                 main_err, data_err;
  core_vec_t                            main_err_cba, data_err_cba;

  always_comb begin
    for (int i = 0; i < NCores; i++) begin
      main_in[i] = {core_req_i[i].busy, core_req_i[i].instr_req,
                    core_req_i[i].data_req, core_req_i[i].instr_addr};
      data_in[i] = {core_req_i[i].data_add, core_req_i[i].data_wen,
                    core_req_i[i].data_wdata, core_req_i[i].data_be};
    end
  end

  lockstep_voter #(
    .Width ( MainVoteWidth )
  ) u_main_voter (
    .a_i         ( main_in[0]   ),
    .b_i         ( main_in[1]   ),
    .c_i         ( main_in[2]   ),
    .majority_o  ( main_out     ),
    .error_o     ( main_err     ),
    .error_cba_o ( main_err_cba )
  );

  // Data fields are separate as they only matter during an access
  lockstep_voter #(
    .Width ( DataVoteWidth )
  ) u_data_voter (
    .a_i         ( data_in[0]   ),
    .b_i         ( data_in[1]   ),
    .c_i         ( data_in[2]   ),
    .majority_o  ( data_out     ),
    .error_o     ( data_err     ),
    .error_cba_o ( data_err_cba )
  );

  always_comb begin
    {voted_o.busy, voted_o.instr_req, voted_o.data_req, voted_o.instr_addr} = main_out;
    {voted_o.data_add, voted_o.data_wen, voted_o.data_wdata, voted_o.data_be} = data_out;
  end

  always_comb begin
    single_err_o = main_err_cba;
    triple_err_o = main_err;
    if (voted_o.data_req) begin
      single_err_o = main_err_cba | data_err_cba;
      triple_err_o = main_err | data_err;
    end
  end

endmodule

// File: lockstep_voter.sv
// ************************************************************
// Bitwise triple majority voter with per-core error flags
// ************************************************************
`timescale 1ns/1ps

module lockstep_voter #(
  parameter int unsigned Width = 32
) (
  input  logic [Width-1:0]         a_i,
  input  logic [Width-1:0]         b_i,
  input  logic [Width-1:0]         c_i,
  output logic [Width-1:0]         majority_o,
  output logic                     error_o,
  output lockstep_pkg::core_vec_t  error_cba_o
);
  import lockstep_pkg::*;

  logic [Width-1:0] diff_a, diff_b, diff_c;

  // Two out of three per bit
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // Bits in which each core is outvoted
  assign diff_a = a_i ^ majority_o;
  assign diff_b = b_i ^ majority_o;
  assign diff_c = c_i ^ majority_o;

  assign error_cba_o = {|diff_c, |diff_b, |diff_a};

  // Every core lost a vote somewhere, so no core can be trusted as a whole
  assign error_o = &error_cba_o;

endmodule

// File: project.f
lockstep_pkg.sv
lockstep_voter.sv
lockstep_vote_stage.sv
lockstep_regs.sv
lockstep_mode_fsm.sv
lockstep_bus_mux.sv
lockstep_top.sv
tb_lockstep.sv

// File: run.sh
#!/bin/sh
# Compile and run the lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lockstep -f project.f

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/Vtb_lockstep

// File: tb_lockstep.sv
// ************************************************************
// Table-driven testbench of the triple-core lockstep unit
// ************************************************************
`timescale 1ns/1ps

module tb_lockstep;
  import lockstep_pkg::*;

  localparam int ResetCycles = 5;
  localparam logic [1:0] OpWr = 2'd1;
  localparam logic [1:0] OpRd = 2'd2;
  localparam core_vec_t FeAll = 3'b111;
  // Mode register bits
  localparam data_t CfgSplit   = 32'h01;
  localparam data_t CfgSetback = 32'h04;
  localparam data_t CfgForce   = 32'h10;
  // Status readback values
  localparam data_t StNonTmr = data_t'(NON_TMR);
  localparam data_t StRun    = data_t'(TMR_RUN);
  localparam data_t StUnload = data_t'(TMR_UNLOAD);
  localparam data_t StReload = data_t'(TMR_RELOAD);

  typedef logic [127:0] cmp_t;

  // One table row with flags {single, triple, resynch, setback}
  typedef struct packed {
    logic [1:0] op;
    reg_addr_t  addr;
    data_t      data;
    logic       dreq;
    core_vec_t  wd_flt;
    core_vec_t  ia_flt;
    logic       synch;
    core_vec_t  fe;
    logic       split;
    logic [3:0] flags;
  } step_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   reg_we_i;
  reg_addr_t              reg_addr_i;
  data_t                  reg_wdata_i;
  data_t                  reg_rdata_o;
  logic                   cores_synch_i;
  core_req_t [NCores-1:0] core_req_i;
  core_req_t [NCores-1:0] intc_req_o;
  bus_rsp_t  [NCores-1:0] intc_rsp_i;
  bus_rsp_t  [NCores-1:0] core_rsp_o;
  core_vec_t              intc_fetch_en_i;
  core_vec_t              core_fetch_en_o;
  core_vec_t              core_setback_o;
  logic                   single_mismatch_o;
  logic                   triple_mismatch_o;
  logic                   resynch_req_o;

  step_t steps[$];
  int    seed = 90;
  int    cycles = 0;

  lockstep_top u_dut (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .reg_we_i          ( reg_we_i          ),
    .reg_addr_i        ( reg_addr_i        ),
    .reg_wdata_i       ( reg_wdata_i       ),
    .reg_rdata_o       ( reg_rdata_o       ),
    .cores_synch_i     ( cores_synch_i     ),
    .core_req_i        ( core_req_i        ),
    .intc_req_o        ( intc_req_o        ),
    .intc_rsp_i        ( intc_rsp_i        ),
    .core_rsp_o        ( core_rsp_o        ),
    .intc_fetch_en_i   ( intc_fetch_en_i   ),
    .core_fetch_en_o   ( core_fetch_en_o   ),
    .core_setback_o    ( core_setback_o    ),
    .single_mismatch_o ( single_mismatch_o ),
    .triple_mismatch_o ( triple_mismatch_o ),
    .resynch_req_o     ( resynch_req_o     )
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > steps.size() + ResetCycles + 50) begin
      $display("Timeout after %0d cycles, the step table never finished", cycles);
      $display("sim failed");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  task automatic expect_equal(input string what, input cmp_t got, input cmp_t exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic add_step(input logic [1:0] op, input reg_addr_t addr, input data_t data,
                          input logic dreq, input core_vec_t wd_flt, input core_vec_t ia_flt,
                          input logic synch, input core_vec_t fe, input logic split,
                          input logic [3:0] flags);
    step_t s;
    s = '{op, addr, data, dreq, wd_flt, ia_flt, synch, fe, split, flags};
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step(OpRd, RegStatus, StRun, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegMis1, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, 3'b001, 1'b0, 4'b0000);
    // Corrupt wdata is ignored without a data request
    add_step(OpRd, RegMis1, 32'd0, 1'b0, 3'b010, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegMis1, 32'd0, 1'b1, 3'b010, 3'b000, 1'b0, FeAll, 1'b0, 4'b1010);
    add_step(OpRd, RegMis1, 32'd1, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    // No counting while unloading
    add_step(OpRd, RegStatus, StUnload, 1'b1, 3'b010, 3'b000, 1'b0, FeAll, 1'b0, 4'b1000);
    add_step(OpRd, RegMis1, 32'd1, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpWr, RegMode, CfgSetback, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpWr, RegSpStore, 32'h1000_0000, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegSpStore, 32'h1000_0000, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StReload, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0001);
    add_step(OpRd, RegMis2, 32'd0, 1'b1, 3'b000, 3'b100, 1'b0, FeAll, 1'b0, 4'b1010);
    add_step(OpWr, RegSpStore, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StReload, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StRun, 1'b1, 3'b000, 3'b000, 1'b0, 3'b110, 1'b0, 4'b0000);
    // Instruction address is voted even without a data request
    add_step(OpRd, RegMis2, 32'd0, 1'b0, 3'b000, 3'b100, 1'b0, FeAll, 1'b0, 4'b1010);
    add_step(OpRd, RegMis2, 32'd1, 1'b1, 3'b111, 3'b000, 1'b0, FeAll, 1'b0, 4'b1100);
    add_step(OpRd, RegMis0, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpWr, RegSpStore, 32'h2000, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StUnload, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpWr, RegSpStore, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0001);
    add_step(OpRd, RegStatus, StReload, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StRun, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    // Split mode and return to lockstep
    add_step(OpWr, RegMode, CfgSplit, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StRun, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StNonTmr, 1'b1, 3'b010, 3'b000, 1'b0, 3'b101, 1'b1, 4'b1000);
    add_step(OpWr, RegMode, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b1, 4'b0000);
    add_step(OpRd, RegStatus, StNonTmr, 1'b1, 3'b000, 3'b000, 1'b1, 3'b010, 1'b1, 4'b0000);
    add_step(OpRd, RegStatus, StRun, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpWr, RegMode, CfgForce, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegMode, CfgForce, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegMode, 32'd0, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegStatus, StUnload, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
    add_step(OpRd, RegMis1, 32'd1, 1'b1, 3'b000, 3'b000, 1'b0, FeAll, 1'b0, 4'b0000);
  endtask

  task automatic run_step(input step_t s);
    core_req_t              base;
    core_req_t              exp_req;
    bus_rsp_t               exp_rsp;
    core_req_t [NCores-1:0] req;
    bus_rsp_t  [NCores-1:0] rsp;
    logic [95:0]            rsp_bits;
    logic [31:0]            rnd;
    @(negedge clk_i);
    // Request that all healthy cores agree on
    rnd = $random(seed);
    base.busy       = 1'b1;
    base.instr_req  = 1'b1;
    base.instr_addr = $random(seed);
    base.data_req   = s.dreq;
    base.data_add   = $random(seed);
    base.data_wen   = rnd[0];
    base.data_wdata = $random(seed);
    base.data_be    = rnd[7:4];
    for (int k = 0; k < NCores; k++) begin
      req[k] = base;
      // Each core's fault flips its own bit, so three faults never form a majority
      if (s.wd_flt[k]) begin
        req[k].data_wdata = req[k].data_wdata ^ (32'h1 << (4 * k));
      end
      if (s.ia_flt[k]) begin
        req[k].instr_addr = req[k].instr_addr ^ (32'h100 << (4 * k));
      end
      rsp_bits = {$random(seed), $random(seed), $random(seed)};
      rsp[k]   = rsp_bits[$bits(bus_rsp_t)-1:0];
    end
    core_req_i      = req;
    intc_rsp_i      = rsp;
    reg_we_i        = (s.op == OpWr);
    reg_addr_i      = s.addr;
    reg_wdata_i     = (s.op == OpWr) ? s.data : '0;
    cores_synch_i   = s.synch;
    intc_fetch_en_i = s.fe;
    #2;
    expect_equal("single_mismatch_o", cmp_t'(single_mismatch_o), cmp_t'(s.flags[3]));
    expect_equal("triple_mismatch_o", cmp_t'(triple_mismatch_o), cmp_t'(s.flags[2]));
    expect_equal("resynch_req_o", cmp_t'(resynch_req_o), cmp_t'(s.flags[1]));
    expect_equal("core_setback_o", cmp_t'(core_setback_o), cmp_t'({NCores{s.flags[0]}}));
    if (s.op == OpRd) begin
      expect_equal("reg_rdata_o", cmp_t'(reg_rdata_o), cmp_t'(s.data));
    end
    for (int k = 0; k < NCores; k++) begin
      if (s.split) begin
        exp_req = req[k];
        exp_rsp = rsp[k];
      end else begin
        // Majority of the cores is the common request
        exp_req = (k == 0) ? base : req[k];
        if (k != 0) begin
          exp_req.busy      = 1'b0;
          exp_req.instr_req = 1'b0;
          exp_req.data_req  = 1'b0;
        end
        exp_rsp = rsp[0];
      end
      expect_equal($sformatf("intc_req_o[%0d]", k), cmp_t'(intc_req_o[k]), cmp_t'(exp_req));
      expect_equal($sformatf("core_rsp_o[%0d]", k), cmp_t'(core_rsp_o[k]), cmp_t'(exp_rsp));
      expect_equal($sformatf("core_fetch_en_o[%0d]", k), cmp_t'(core_fetch_en_o[k]),
                   cmp_t'(s.split ? s.fe[k] : s.fe[0]));
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    reg_we_i        = 1'b0;
    reg_addr_i      = '0;
    reg_wdata_i     = '0;
    cores_synch_i   = 1'b0;
    core_req_i      = '0;
    intc_rsp_i      = '0;
    intc_fetch_en_i = FeAll;
    build_table();
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("sim passed");
    $finish;
  end

endmodule
